//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal
TOP ?= camera_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the camera testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
+incdir+hw
hw/key_pkg.sv
hw/camera_pkg.sv
hw/key_event_decoder.sv
hw/command_fifo.sv
hw/camera_rotator.sv
hw/camera_datapath.sv
hw/camera_controller.sv
hw/camera_subsystem.sv
sim/camera_tb.sv

//--- hw/camera_controller.sv
`include "camera_defines.svh"

module camera_controller import key_pkg::*, camera_pkg::*; (
	input logic clk,
	input logic rst,
	input camera_cmd_t cmd,
	input logic cmd_valid,
	output logic cmd_ready,
	input logic rendering_done,
	output logic render_frame,
	output camera_t camera
);

	typedef enum logic [1:0] {
		IDLE,
		MOVING,
		WAIT_FRAME
	} state_t;

	state_t state;
	state_t state_n;
	vector_t u, v, w;
	vector_t u_n, v_n, w_n;
	vector_t e;
	key_code_t move_key;
	key_code_t step_key;
	logic stop_seen;
	logic accept;
	logic stop_now;
	logic step_en;
	logic scale_en;
	logic rot_en;
	logic frame_n;

	// a taken stop closes the queue until the last frame returns
	assign cmd_ready = (state == IDLE) || ((state == MOVING) && !stop_seen);
	assign accept = cmd_valid && cmd_ready;
	assign stop_now = accept && (state == MOVING) && (cmd.op == CMD_STOP);

	assign step_key = (state == IDLE) ? cmd.key : move_key;
	assign camera = '{e: e, u: u, v: v, w: w};

	always_comb begin
		state_n = state;
		step_en = 1'b0;
		scale_en = 1'b0;
		rot_en = 1'b0;
		frame_n = 1'b0;
		case (state)
			IDLE: begin
				if (accept) begin
					case (cmd.op)
						CMD_MOVE: begin
							step_en = 1'b1;
							frame_n = 1'b1;
							state_n = MOVING;
						end
						CMD_ROTATE: begin
							rot_en = 1'b1;
							frame_n = 1'b1;
							state_n = WAIT_FRAME;
						end
						CMD_SCALE: scale_en = 1'b1;
						default: ;
					endcase
				end
			end
			MOVING: begin
				if (rendering_done) begin
					if (stop_seen || stop_now) begin
						state_n = IDLE;
					end else begin
						step_en = 1'b1;
						frame_n = 1'b1;
					end
				end
			end
			WAIT_FRAME: begin
				if (rendering_done)
					state_n = IDLE;
			end
			default: state_n = IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= IDLE;
			render_frame <= 1'b0;
			stop_seen <= 1'b0;
			u <= '{x: `RESET_UNIT, y: '0, z: '0};
			v <= '{x: '0, y: `RESET_UNIT, z: '0};
			w <= '{x: '0, y: '0, z: `RESET_UNIT};
		end else begin
			state <= state_n;
			render_frame <= frame_n;
			if (state != MOVING)
				stop_seen <= 1'b0;
			else if (stop_now)
				stop_seen <= 1'b1;
			if (rot_en) begin
				u <= u_n;
				v <= v_n;
				w <= w_n;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && (state == IDLE) && (cmd.op == CMD_MOVE))
			move_key <= cmd.key;
	end

	camera_rotator camera_rotator_i (
		.key(cmd.key),
		.u(u),
		.v(v),
		.w(w),
		.u_n(u_n),
		.v_n(v_n),
		.w_n(w_n)
	);

	camera_datapath camera_datapath_i (
		.clk(clk),
		.rst(rst),
		.key(step_key),
		.basis(camera),
		.step_en(step_en),
		.scale_en(scale_en),
		.e(e)
	);

endmodule

//--- hw/camera_datapath.sv
`include "camera_defines.svh"

module camera_datapath import key_pkg::*, camera_pkg::*; (
	input logic clk,
	input logic rst,
	input key_code_t key,
	input camera_t basis,
	input logic step_en,
	input logic scale_en,
	output vector_t e
);

	// scale is 1 << scale_exp units
	logic [1:0] scale_exp;
	vector_t axis;
	vector_t shifted;
	vector_t step;

	// d/a on U, e/q on V, w/s on W
	always_comb begin
		case (key[3:1])
			3'd0: axis = basis.u;
			3'd1: axis = basis.v;
			3'd2: axis = basis.w;
			default: axis = '0;
		endcase
	end

	assign shifted = '{x: axis.x <<< scale_exp,
		y: axis.y <<< scale_exp,
		z: axis.z <<< scale_exp};

	// odd codes move backwards
	assign step = key[0] ? vec_neg(shifted) : shifted;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			scale_exp <= 2'd0;
			e <= `RESET_E;
		end else begin
			// n7..n0 map to exponents 0..3
			if (scale_en)
				scale_exp <= 2'(key - KEY_N7);
			if (step_en)
				e <= vec_add(e, step);
		end
	end

endmodule

//--- hw/camera_defines.svh
`ifndef CAMERA_DEFINES_SVH
`define CAMERA_DEFINES_SVH

// signed Q8.8 coordinates
`define COORD_W 16
`define FRAC_W 8

// one unit in fixed point, the length of each basis vector at reset
`define RESET_UNIT (`COORD_W'(1) << `FRAC_W)

// eye starts at the origin
`define RESET_E '0

`define CMD_FIFO_DEPTH 4

`endif

//--- hw/camera_pkg.sv
`include "camera_defines.svh"

package camera_pkg;

	typedef logic signed [`COORD_W-1:0] coord_t;

	typedef struct packed {
		coord_t x, y, z;
	} vector_t;

	// view handed to the renderer
	typedef struct packed {
		vector_t e, u, v, w;
	} camera_t;

	function automatic vector_t vec_neg(input vector_t a);
		return '{x: -a.x, y: -a.y, z: -a.z};
	endfunction

	// wraps at COORD_W bits
	function automatic vector_t vec_add(input vector_t a, input vector_t b);
		return '{x: a.x + b.x, y: a.y + b.y, z: a.z + b.z};
	endfunction

endpackage

//--- hw/camera_rotator.sv
module camera_rotator import key_pkg::*, camera_pkg::*; (
	input key_code_t key,
	input vector_t u,
	input vector_t v,
	input vector_t w,
	output vector_t u_n,
	output vector_t v_n,
	output vector_t w_n
);

	// quarter turns only, so swaps and negations are exact
	always_comb begin
		u_n = u;
		v_n = v;
		w_n = w;
		case (key)
			// about V
			KEY_L: begin
				u_n = w;
				w_n = vec_neg(u);
			end
			KEY_J: begin
				u_n = vec_neg(w);
				w_n = u;
			end
			// about U
			KEY_O: begin
				v_n = w;
				w_n = vec_neg(v);
			end
			KEY_U: begin
				v_n = vec_neg(w);
				w_n = v;
			end
			// about W
			KEY_I: begin
				u_n = v;
				v_n = vec_neg(u);
			end
			KEY_K: begin
				u_n = vec_neg(v);
				v_n = u;
			end
			default: ;
		endcase
	end

endmodule

//--- hw/camera_subsystem.sv
module camera_subsystem import key_pkg::*, camera_pkg::*; (
	input logic clk,
	input logic rst,
	input keys_t keys,
	input logic keys_valid,
	output logic keys_ready,
	input logic rendering_done,
	output logic render_frame,
	output camera_t camera
);

	camera_cmd_t cmd_in;
	logic in_valid;
	logic in_ready;
	camera_cmd_t cmd_out;
	logic out_valid;
	logic out_ready;

	key_event_decoder key_event_decoder_i (
		.clk(clk),
		.rst(rst),
		.keys(keys),
		.keys_valid(keys_valid),
		.keys_ready(keys_ready),
		.cmd(cmd_in),
		.cmd_valid(in_valid),
		.cmd_ready(in_ready)
	);

	// absorbs commands while a frame is outstanding
	command_fifo #(
		.entry_t(camera_cmd_t)
	) command_fifo_i (
		.clk(clk),
		.rst(rst),
		.in_data(cmd_in),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_data(cmd_out),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	camera_controller camera_controller_i (
		.clk(clk),
		.rst(rst),
		.cmd(cmd_out),
		.cmd_valid(out_valid),
		.cmd_ready(out_ready),
		.rendering_done(rendering_done),
		.render_frame(render_frame),
		.camera(camera)
	);

endmodule

//--- hw/command_fifo.sv
`include "camera_defines.svh"

module command_fifo #(
	parameter type entry_t = logic [7:0]
) (
	input logic clk,
	input logic rst,
	input entry_t in_data,
	input logic in_valid,
	output logic in_ready,
	output entry_t out_data,
	output logic out_valid,
	input logic out_ready
);

	localparam int DEPTH = `CMD_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	entry_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic wr_en;
	logic rd_en;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign in_ready = (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];
	assign wr_en = in_valid && in_ready;
	assign rd_en = out_valid && out_ready;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= next_ptr(wr_ptr);
			if (rd_en)
				rd_ptr <= next_ptr(rd_ptr);
			// simultaneous write and read keeps the count
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= in_data;
	end

endmodule

//--- hw/key_event_decoder.sv
module key_event_decoder import key_pkg::*; (
	input logic clk,
	input logic rst,
	input keys_t keys,
	input logic keys_valid,
	output logic keys_ready,
	output camera_cmd_t cmd,
	output logic cmd_valid,
	input logic cmd_ready
);

	logic [15:0] press;
	logic [15:0] rel;
	logic [4:0] press_cnt;
	key_code_t press_key;
	logic single_press;
	logic release_only;
	logic emit;
	logic accept;
	camera_cmd_t cmd_n;

	// bit index equals key code
	assign press = {keys.n0[0], keys.n9[0], keys.n8[0], keys.n7[0],
		keys.k[0], keys.i[0], keys.u[0], keys.o[0],
		keys.j[0], keys.l[0], keys.s[0], keys.w[0],
		keys.q[0], keys.e[0], keys.a[0], keys.d[0]};
	assign rel = {keys.n0[1], keys.n9[1], keys.n8[1], keys.n7[1],
		keys.k[1], keys.i[1], keys.u[1], keys.o[1],
		keys.j[1], keys.l[1], keys.s[1], keys.w[1],
		keys.q[1], keys.e[1], keys.a[1], keys.d[1]};

	// count presses, remember the last one found
	always_comb begin
		press_cnt = '0;
		press_key = '0;
		for (int i = 0; i < 16; i++) begin
			if (press[i]) begin
				press_cnt = press_cnt + 5'd1;
				press_key = key_code_t'(i);
			end
		end
	end

	assign single_press = (press_cnt == 5'd1);
	assign release_only = (press_cnt == 5'd0) && (|rel);
	assign emit = single_press || release_only;

	always_comb begin
		cmd_n.key = press_key;
		if (release_only)
			cmd_n.op = CMD_STOP;
		else if (press_key < KEY_L)
			cmd_n.op = CMD_MOVE;
		else if (press_key < KEY_N7)
			cmd_n.op = CMD_ROTATE;
		else
			cmd_n.op = CMD_SCALE;
	end

	// one-entry output register
	assign keys_ready = !cmd_valid || cmd_ready;
	assign accept = keys_valid && keys_ready;

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			cmd_valid <= 1'b0;
		else if (accept)
			cmd_valid <= emit;
		else if (cmd_ready)
			cmd_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept && emit)
			cmd <= cmd_n;
	end

endmodule

//--- hw/key_pkg.sv
package key_pkg;

	// bit 0 is press, bit 1 is release
	typedef logic [1:0] key_pair_t;

	// one pair per key, d in the top bits
	typedef struct packed {
		key_pair_t d, a;
		key_pair_t e, q;
		key_pair_t w, s;
		key_pair_t l, j;
		key_pair_t o, u;
		key_pair_t i, k;
		key_pair_t n7, n8, n9, n0;
	} keys_t;

	// 0..5 move, 6..11 rotate, 12..15 scale
	typedef logic [3:0] key_code_t;

	localparam key_code_t KEY_L = 4'd6;
	localparam key_code_t KEY_J = 4'd7;
	localparam key_code_t KEY_O = 4'd8;
	localparam key_code_t KEY_U = 4'd9;
	localparam key_code_t KEY_I = 4'd10;
	localparam key_code_t KEY_K = 4'd11;
	localparam key_code_t KEY_N7 = 4'd12;

	typedef enum logic [1:0] {
		CMD_MOVE,
		CMD_ROTATE,
		CMD_SCALE,
		CMD_STOP
	} cmd_op_t;

	typedef struct packed {
		cmd_op_t op;
		key_code_t key;
	} camera_cmd_t;

endpackage

//--- sim/camera_tb.sv
`include "camera_defines.svh"

module camera_tb import key_pkg::*, camera_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_TESTS = 17;
	localparam int MAX_FRAMES = 3;
	localparam int MAX_DELAY = 6;
	localparam int TIMEOUT = N_TESTS * (MAX_FRAMES + 1) * (MAX_DELAY + 8);
	localparam int UNIT = 1 << `FRAC_W;

	logic clk = 1'b0;
	logic rst = 1'b1;
	keys_t keys = '0;
	logic keys_valid = 1'b0;
	logic keys_ready;
	logic rendering_done = 1'b0;
	logic render_frame;
	camera_t camera;

	// test table
	string t_name [N_TESTS];
	int t_code [N_TESTS];
	int t_frames [N_TESTS];
	camera_t t_exp [N_TESTS];
	int n_tests = 0;

	// reference model, expected frames and renderer state
	camera_t m_cam;
	int m_exp = 0;
	int frame_q [$];
	string cur_name = "reset";
	logic outstanding = 1'b0;
	int delay_left = 0;
	int answered = 0;
	int answer_max = 0;
	integer seed = 32'h572;
	int cycles = 0;
	vector_t px, nx, py, ny, pz;

	camera_subsystem camera_subsystem_i (
		.clk(clk),
		.rst(rst),
		.keys(keys),
		.keys_valid(keys_valid),
		.keys_ready(keys_ready),
		.rendering_done(rendering_done),
		.render_frame(render_frame),
		.camera(camera)
	);

	always #20 clk = ~clk;

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [191:0] expected,
		input logic [191:0] actual);
		if (expected !== actual)
			stop_with_error($sformatf("mismatch in %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	function automatic vector_t vec(input int x, input int y, input int z);
		return '{x: coord_t'(x * UNIT), y: coord_t'(y * UNIT), z: coord_t'(z * UNIT)};
	endfunction

	function automatic vector_t flip(input vector_t a);
		return '{x: -a.x, y: -a.y, z: -a.z};
	endfunction

	function automatic coord_t stepped(input coord_t e, input coord_t a, input int k);
		return coord_t'(e + a * k);
	endfunction

	// d is the top pair, release above press
	function automatic keys_t packet(input int code, input bit rel);
		logic [31:0] bits;
		bits = '0;
		bits[5'(rel ? 31 - 2 * code : 30 - 2 * code)] = 1'b1;
		return keys_t'(bits);
	endfunction

	task automatic apply_frame(input int code);
		vector_t axis;
		vector_t u, v, w;
		int k;
		u = m_cam.u;
		v = m_cam.v;
		w = m_cam.w;
		if (code < 6) begin
			axis = (code < 2) ? u : (code < 4) ? v : w;
			k = (code % 2 == 1) ? -(1 << m_exp) : (1 << m_exp);
			m_cam.e.x = stepped(m_cam.e.x, axis.x, k);
			m_cam.e.y = stepped(m_cam.e.y, axis.y, k);
			m_cam.e.z = stepped(m_cam.e.z, axis.z, k);
		end else begin
			case (code)
				6: begin
					m_cam.u = w;
					m_cam.w = flip(u);
				end
				7: begin
					m_cam.u = flip(w);
					m_cam.w = u;
				end
				8: begin
					m_cam.v = w;
					m_cam.w = flip(v);
				end
				9: begin
					m_cam.v = flip(w);
					m_cam.w = v;
				end
				10: begin
					m_cam.u = v;
					m_cam.v = flip(u);
				end
				default: begin
					m_cam.u = flip(v);
					m_cam.v = u;
				end
			endcase
		end
	endtask

	task automatic add(input string name, input int code, input int frames,
		input vector_t e, input vector_t u, input vector_t v, input vector_t w);
		t_name[n_tests] = name;
		t_code[n_tests] = code;
		t_frames[n_tests] = frames;
		t_exp[n_tests] = '{e: e, u: u, v: v, w: w};
		n_tests++;
	endtask

	// called on a falling edge, returns on the falling edge after the transfer
	task automatic send(input keys_t pkt);
		keys = pkt;
		keys_valid = 1'b1;
		while (!keys_ready)
			@(negedge clk);
		@(negedge clk);
		keys = '0;
		keys_valid = 1'b0;
	endtask

	task automatic settle();
		do
			@(posedge clk);
		while (frame_q.size() != 0 || outstanding);
		// a late frame in the quiet period shows up as unexpected
		repeat (8) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic run_test(input int i);
		int code;
		code = t_code[i];
		cur_name = t_name[i];
		if (code < 0) begin
			send(keys_t'(packet(0, 1'b0) | packet(1, 1'b0)));
		end else if (code < 6) begin
			repeat (t_frames[i]) frame_q.push_back(code);
			// last frame held back so the release lands before its answer
			answer_max = answered + t_frames[i] - 1;
			send(packet(code, 1'b0));
			do
				@(posedge clk);
			while (frame_q.size() != 0);
			@(negedge clk);
			send(packet(code, 1'b1));
			// decoder, fifo and controller take one cycle each
			repeat (4) @(posedge clk);
			answer_max = answered + 1;
		end else if (code < 12) begin
			frame_q.push_back(code);
			answer_max = answered + 1;
			send(packet(code, 1'b0));
		end else begin
			m_exp = code - 12;
			send(packet(code, 1'b0));
		end
		settle();
		check(t_name[i], t_exp[i], camera);
	endtask

	task automatic burst();
		int codes [8];
		codes = '{6, 7, 8, 9, 10, 11, 10, 11};
		cur_name = "burst";
		answer_max = answered;
		foreach (codes[j])
			frame_q.push_back(codes[j]);
		for (int j = 0; j < 6; j++)
			send(packet(codes[j], 1'b0));
		// one in the controller, four in the fifo, one in the decoder
		check("burst_full", 192'(0), 192'(keys_ready));
		@(posedge clk);
		answer_max = answered + 8;
		@(negedge clk);
		send(packet(codes[6], 1'b0));
		send(packet(codes[7], 1'b0));
		settle();
		check("burst_end", t_exp[N_TESTS - 1], camera);
	endtask

	// frame monitor and renderer model
	always @(negedge clk) begin
		rendering_done = 1'b0;
		if (render_frame) begin
			if (outstanding)
				stop_with_error("render_frame rose again before rendering_done");
			else if (frame_q.size() == 0)
				stop_with_error($sformatf("unexpected frame during %s", cur_name));
			else begin
				apply_frame(frame_q.pop_front());
				check({cur_name, " frame"}, m_cam, camera);
				outstanding = 1'b1;
				delay_left = 1 + ($unsigned($random(seed)) % MAX_DELAY);
			end
		end
		if (outstanding && answered < answer_max) begin
			delay_left--;
			if (delay_left == 0) begin
				rendering_done = 1'b1;
				outstanding = 1'b0;
				answered++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT)
			stop_with_error($sformatf("run did not finish within %0d cycles", TIMEOUT));
	end

	initial begin
		px = vec(1, 0, 0);
		nx = vec(-1, 0, 0);
		py = vec(0, 1, 0);
		ny = vec(0, -1, 0);
		pz = vec(0, 0, 1);
		m_cam = '{e: vec(0, 0, 0), u: px, v: py, w: pz};
		// codes 0..5 move, 6..11 rotate, 12..15 scale, -1 two presses
		add("move_d", 0, 3, vec(3, 0, 0), px, py, pz);
		add("scale_n8", 13, 0, vec(3, 0, 0), px, py, pz);
		add("move_e", 2, 2, vec(3, 4, 0), px, py, pz);
		add("rot_l", 6, 0, vec(3, 4, 0), pz, py, nx);
		add("move_a", 1, 2, vec(3, 4, -4), pz, py, nx);
		add("rot_j", 7, 0, vec(3, 4, -4), px, py, pz);
		add("rot_o", 8, 0, vec(3, 4, -4), px, pz, ny);
		add("rot_u", 9, 0, vec(3, 4, -4), px, py, pz);
		add("rot_i", 10, 0, vec(3, 4, -4), py, nx, pz);
		add("junk", -1, 0, vec(3, 4, -4), py, nx, pz);
		add("scale_n0", 15, 0, vec(3, 4, -4), py, nx, pz);
		add("move_q", 3, 1, vec(11, 4, -4), py, nx, pz);
		add("rot_k", 11, 0, vec(11, 4, -4), px, py, pz);
		add("scale_n9", 14, 0, vec(11, 4, -4), px, py, pz);
		add("move_s", 5, 1, vec(11, 4, -8), px, py, pz);
		add("scale_n7", 12, 0, vec(11, 4, -8), px, py, pz);
		add("move_w", 4, 2, vec(11, 4, -6), px, py, pz);
		repeat (2) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check("reset_frame", 192'(0), 192'(render_frame));
		check("reset_ready", 192'(1), 192'(keys_ready));
		check("reset_camera", m_cam, camera);
		for (int i = 0; i < n_tests; i++)
			run_test(i);
		burst();
		$display("No errors");
		$finish;
	end

endmodule
